//--- verilog/decode_pkg.sv
`default_nettype none

package decode_pkg;

  localparam int INST_WIDTH     = 16;
  localparam int REG_ADDR_WIDTH = 4;

  typedef logic [INST_WIDTH-1:0]     inst_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

  typedef enum logic [2:0] {
    CLASS_NOP,
    CLASS_EXT,
    CLASS_MOV,
    CLASS_LDSTR,
    CLASS_ALU,
    CLASS_SHIFT,
    CLASS_ILLEGAL
  } inst_class_e;

  typedef enum logic [3:0] {
    ALU_AND = 4'h0, ALU_OR  = 4'h1, ALU_XOR = 4'h2, ALU_NOT = 4'h3,
    ALU_NEG = 4'h4, ALU_MUL = 4'h5, ALU_DIV = 4'h6, ALU_REM = 4'h7,
    ALU_ADD = 4'h8, ALU_SUB = 4'h9, ALU_SEX = 4'ha, ALU_ZEX = 4'hb,
    ALU_LSR = 4'hc, ALU_LSL = 4'hd, ALU_ASR = 4'he, ALU_MOV = 4'hf
  } alu_op_e;

  // Class identifiers on bits 15..12, the paired classes ignore bit 12
  localparam int IDENT_HIGH = 15;
  localparam int IDENT_LOW  = 12;
  localparam logic [3:0] IDENT_NOP   = 4'b0000;
  localparam logic [3:0] IDENT_EXT   = 4'b0001;
  localparam logic [3:0] IDENT_MOV   = 4'b0100;
  localparam logic [3:0] IDENT_LDSTR = 4'b0110;
  localparam logic [3:0] IDENT_ALU   = 4'b1000;
  localparam logic [3:0] IDENT_SHIFT = 4'b1010;

  // Operand source for mov/alu/shift, load or store for ldstr
  localparam int SRC_BIT       = 12;
  localparam int EXT_ZERO_BIT  = 11;
  localparam int EXT_16_BIT    = 10;
  localparam int ALU_OP_HIGH   = 11;
  localparam int ALU_OP_LOW    = 8;
  localparam int SHIFT_OP_HIGH = 7;
  localparam int SHIFT_OP_LOW  = 6;

  // Register and literal fields
  localparam int FIELD_HI_HIGH = 11;
  localparam int FIELD_HI_LOW  = 8;
  localparam int FIELD_MID_HIGH = 7;
  localparam int FIELD_MID_LOW  = 4;
  localparam int FIELD_LO_HIGH = 3;
  localparam int FIELD_LO_LOW  = 0;
  localparam int MOV_LIT_HIGH   = 7;
  localparam int SHIFT_LIT_HIGH = 4;

endpackage

`default_nettype wire

//--- verilog/inst_capture.sv
`default_nettype none

module inst_capture (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire decode_pkg::inst_t instruction,
  input  wire logic              inst_valid,
  input  wire logic              next_ready,
  output decode_pkg::inst_t      held_inst,
  output logic                   held_valid
);

  // A cleared valid moves on as a bubble
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      held_valid <= 1'b0;
    end
    else if (next_ready)
    begin
      held_valid <= inst_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (next_ready && inst_valid)
    begin
      held_inst <= instruction;
    end
  end

endmodule

`default_nettype wire

//--- verilog/class_decode.sv
`default_nettype none

module class_decode (
  input  wire decode_pkg::inst_t  held_inst,
  output decode_pkg::inst_class_e inst_class,
  output decode_pkg::alu_op_e     alu_opcode,
  output logic                    op2_is_literal,
  output logic                    ext_16,
  output logic                    set_flags,
  output logic                    mem_read,
  output logic                    mem_write,
  output logic                    reg_write,
  output logic                    reg_write_from_mem
);

  logic [3:0] ident;
  logic [3:0] ident_pair;
  logic       src;

  assign ident      = held_inst[decode_pkg::IDENT_HIGH:decode_pkg::IDENT_LOW];
  assign ident_pair = {ident[3:1], 1'b0};
  assign src        = held_inst[decode_pkg::SRC_BIT];

  // nop and ext take all four bits, the rest only the upper three
  always_comb
  begin
    if (ident == decode_pkg::IDENT_NOP)
      inst_class = decode_pkg::CLASS_NOP;
    else if (ident == decode_pkg::IDENT_EXT)
      inst_class = decode_pkg::CLASS_EXT;
    else
    begin
      case (ident_pair)
        decode_pkg::IDENT_MOV:   inst_class = decode_pkg::CLASS_MOV;
        decode_pkg::IDENT_LDSTR: inst_class = decode_pkg::CLASS_LDSTR;
        decode_pkg::IDENT_ALU:   inst_class = decode_pkg::CLASS_ALU;
        decode_pkg::IDENT_SHIFT: inst_class = decode_pkg::CLASS_SHIFT;
        default:                 inst_class = decode_pkg::CLASS_ILLEGAL;
      endcase
    end
  end

  always_comb
  begin
    alu_opcode         = decode_pkg::ALU_AND;
    op2_is_literal     = 1'b0;
    ext_16             = 1'b0;
    set_flags          = 1'b0;
    mem_read           = 1'b0;
    mem_write          = 1'b0;
    reg_write          = 1'b0;
    reg_write_from_mem = 1'b0;

    case (inst_class)
      decode_pkg::CLASS_EXT:
      begin
        alu_opcode = held_inst[decode_pkg::EXT_ZERO_BIT] ? decode_pkg::ALU_ZEX
                                                         : decode_pkg::ALU_SEX;
        ext_16     = held_inst[decode_pkg::EXT_16_BIT];
        reg_write  = 1'b1;
      end
      decode_pkg::CLASS_MOV:
      begin
        alu_opcode     = decode_pkg::ALU_MOV;
        op2_is_literal = src;
        reg_write      = 1'b1;
      end
      decode_pkg::CLASS_LDSTR:
      begin
        // Address is base plus offset
        alu_opcode         = decode_pkg::ALU_ADD;
        op2_is_literal     = 1'b1;
        mem_read           = !src;
        mem_write          = src;
        reg_write          = !src;
        reg_write_from_mem = !src;
      end
      decode_pkg::CLASS_ALU:
      begin
        alu_opcode = decode_pkg::alu_op_e'(
          held_inst[decode_pkg::ALU_OP_HIGH:decode_pkg::ALU_OP_LOW]);
        op2_is_literal = !src;
        set_flags      = 1'b1;
        reg_write      = 1'b1;
      end
      decode_pkg::CLASS_SHIFT:
      begin
        alu_opcode = decode_pkg::alu_op_e'(decode_pkg::ALU_LSR +
          4'(held_inst[decode_pkg::SHIFT_OP_HIGH:decode_pkg::SHIFT_OP_LOW]));
        op2_is_literal = !src;
        set_flags      = 1'b1;
        reg_write      = 1'b1;
      end
      default:
      begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/operand_select.sv
`default_nettype none

module operand_select #(
  parameter int DATA_WIDTH = 32
) (
  input  wire decode_pkg::inst_t       held_inst,
  input  wire decode_pkg::inst_class_e inst_class,
  output decode_pkg::reg_addr_t        rd_addr,
  output decode_pkg::reg_addr_t        rn_addr,
  output decode_pkg::reg_addr_t        reg_write_addr,
  output logic [DATA_WIDTH-1:0]        literal
);

  decode_pkg::reg_addr_t field_hi;
  decode_pkg::reg_addr_t field_mid;
  decode_pkg::reg_addr_t field_lo;

  assign field_hi  = held_inst[decode_pkg::FIELD_HI_HIGH:decode_pkg::FIELD_HI_LOW];
  assign field_mid = held_inst[decode_pkg::FIELD_MID_HIGH:decode_pkg::FIELD_MID_LOW];
  assign field_lo  = held_inst[decode_pkg::FIELD_LO_HIGH:decode_pkg::FIELD_LO_LOW];

  // Literals are always zero extended
  always_comb
  begin
    rd_addr        = '0;
    rn_addr        = '0;
    reg_write_addr = '0;
    literal        = '0;

    case (inst_class)
      decode_pkg::CLASS_EXT:
      begin
        rd_addr        = field_mid;
        reg_write_addr = field_mid;
      end
      decode_pkg::CLASS_MOV:
      begin
        rn_addr        = field_lo;
        reg_write_addr = field_hi;
        literal        = DATA_WIDTH'(held_inst[decode_pkg::MOV_LIT_HIGH:0]);
      end
      decode_pkg::CLASS_LDSTR:
      begin
        // Base register in the middle field, data register on top
        rd_addr        = field_mid;
        rn_addr        = field_hi;
        reg_write_addr = field_hi;
        literal        = DATA_WIDTH'(field_lo);
      end
      decode_pkg::CLASS_ALU:
      begin
        rd_addr        = field_mid;
        rn_addr        = field_lo;
        reg_write_addr = field_mid;
        literal        = DATA_WIDTH'(field_lo);
      end
      decode_pkg::CLASS_SHIFT:
      begin
        rd_addr        = field_hi;
        rn_addr        = field_lo;
        reg_write_addr = field_hi;
        literal        = DATA_WIDTH'(held_inst[decode_pkg::SHIFT_LIT_HIGH:0]);
      end
      default:
      begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/ctrl_issue.sv
`default_nettype none

module ctrl_issue #(
  parameter int DATA_WIDTH = 32
) (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    next_ready,
  input  wire logic                    held_valid,
  input  wire decode_pkg::inst_class_e inst_class,
  input  wire decode_pkg::alu_op_e     dec_alu_opcode,
  input  wire logic                    dec_op2_is_literal,
  input  wire logic                    dec_ext_16,
  input  wire logic                    dec_set_flags,
  input  wire logic                    dec_mem_read,
  input  wire logic                    dec_mem_write,
  input  wire logic                    dec_reg_write,
  input  wire logic                    dec_reg_write_from_mem,
  input  wire decode_pkg::reg_addr_t   dec_rd_addr,
  input  wire decode_pkg::reg_addr_t   dec_rn_addr,
  input  wire decode_pkg::reg_addr_t   dec_reg_write_addr,
  input  wire logic [DATA_WIDTH-1:0]   dec_literal,
  output logic                         control_valid,
  output logic                         illegal_inst,
  output decode_pkg::alu_op_e          alu_opcode,
  output logic                         op2_is_literal,
  output logic                         ext_16,
  output logic                         set_flags,
  output logic                         mem_read,
  output logic                         mem_write,
  output logic                         reg_write,
  output logic                         reg_write_from_mem,
  output decode_pkg::reg_addr_t        rd_addr,
  output decode_pkg::reg_addr_t        rn_addr,
  output decode_pkg::reg_addr_t        reg_write_addr,
  output logic [DATA_WIDTH-1:0]        literal
);

  logic is_illegal;
  logic enable_ok;

  assign is_illegal = (inst_class == decode_pkg::CLASS_ILLEGAL);
  // Bubbles and illegal words never carry a side effect
  assign enable_ok  = held_valid && !is_illegal;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      control_valid <= 1'b0;
      illegal_inst  <= 1'b0;
      set_flags     <= 1'b0;
      mem_read      <= 1'b0;
      mem_write     <= 1'b0;
      reg_write     <= 1'b0;
    end
    else if (next_ready)
    begin
      control_valid <= held_valid;
      illegal_inst  <= held_valid && is_illegal;
      set_flags     <= enable_ok && dec_set_flags;
      mem_read      <= enable_ok && dec_mem_read;
      mem_write     <= enable_ok && dec_mem_write;
      reg_write     <= enable_ok && dec_reg_write;
    end
  end

  always_ff @(posedge clk)
  begin
    if (next_ready)
    begin
      alu_opcode         <= dec_alu_opcode;
      op2_is_literal     <= dec_op2_is_literal;
      ext_16             <= dec_ext_16;
      reg_write_from_mem <= dec_reg_write_from_mem;
      rd_addr            <= dec_rd_addr;
      rn_addr            <= dec_rn_addr;
      reg_write_addr     <= dec_reg_write_addr;
      literal            <= dec_literal;
    end
  end

endmodule

`default_nettype wire

//--- verilog/decode_top.sv
`default_nettype none

module decode_top #(
  parameter int DATA_WIDTH = 32
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire decode_pkg::inst_t instruction,
  input  wire logic              inst_valid,
  input  wire logic              next_ready,
  output logic                   decode_ready,
  output logic                   control_valid,
  output decode_pkg::reg_addr_t  rd_addr,
  output decode_pkg::reg_addr_t  rn_addr,
  output logic [DATA_WIDTH-1:0]  literal,
  output logic                   op2_is_literal,
  output logic                   ext_16,
  output decode_pkg::alu_op_e    alu_opcode,
  output logic                   set_flags,
  output logic                   mem_read,
  output logic                   mem_write,
  output logic                   reg_write,
  output logic                   reg_write_from_mem,
  output decode_pkg::reg_addr_t  reg_write_addr,
  output logic                   illegal_inst
);

  decode_pkg::inst_t       held_inst;
  logic                    held_valid;
  decode_pkg::inst_class_e inst_class;
  decode_pkg::alu_op_e     dec_alu_opcode;
  logic                    dec_op2_is_literal;
  logic                    dec_ext_16;
  logic                    dec_set_flags;
  logic                    dec_mem_read;
  logic                    dec_mem_write;
  logic                    dec_reg_write;
  logic                    dec_reg_write_from_mem;
  decode_pkg::reg_addr_t   dec_rd_addr;
  decode_pkg::reg_addr_t   dec_rn_addr;
  decode_pkg::reg_addr_t   dec_reg_write_addr;
  logic [DATA_WIDTH-1:0]   dec_literal;

  // Both stages advance together, so upstream sees the downstream ready
  assign decode_ready = next_ready;

  inst_capture u_inst_capture (
    .clk        (clk),
    .rst_n      (rst_n),
    .instruction(instruction),
    .inst_valid (inst_valid),
    .next_ready (next_ready),
    .held_inst  (held_inst),
    .held_valid (held_valid)
  );

  class_decode u_class_decode (
    .held_inst         (held_inst),
    .inst_class        (inst_class),
    .alu_opcode        (dec_alu_opcode),
    .op2_is_literal    (dec_op2_is_literal),
    .ext_16            (dec_ext_16),
    .set_flags         (dec_set_flags),
    .mem_read          (dec_mem_read),
    .mem_write         (dec_mem_write),
    .reg_write         (dec_reg_write),
    .reg_write_from_mem(dec_reg_write_from_mem)
  );

  operand_select #(
    .DATA_WIDTH(DATA_WIDTH)
  ) u_operand_select (
    .held_inst     (held_inst),
    .inst_class    (inst_class),
    .rd_addr       (dec_rd_addr),
    .rn_addr       (dec_rn_addr),
    .reg_write_addr(dec_reg_write_addr),
    .literal       (dec_literal)
  );

  ctrl_issue #(
    .DATA_WIDTH(DATA_WIDTH)
  ) u_ctrl_issue (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .next_ready            (next_ready),
    .held_valid            (held_valid),
    .inst_class            (inst_class),
    .dec_alu_opcode        (dec_alu_opcode),
    .dec_op2_is_literal    (dec_op2_is_literal),
    .dec_ext_16            (dec_ext_16),
    .dec_set_flags         (dec_set_flags),
    .dec_mem_read          (dec_mem_read),
    .dec_mem_write         (dec_mem_write),
    .dec_reg_write         (dec_reg_write),
    .dec_reg_write_from_mem(dec_reg_write_from_mem),
    .dec_rd_addr           (dec_rd_addr),
    .dec_rn_addr           (dec_rn_addr),
    .dec_reg_write_addr    (dec_reg_write_addr),
    .dec_literal           (dec_literal),
    .control_valid         (control_valid),
    .illegal_inst          (illegal_inst),
    .alu_opcode            (alu_opcode),
    .op2_is_literal        (op2_is_literal),
    .ext_16                (ext_16),
    .set_flags             (set_flags),
    .mem_read              (mem_read),
    .mem_write             (mem_write),
    .reg_write             (reg_write),
    .reg_write_from_mem    (reg_write_from_mem),
    .rd_addr               (rd_addr),
    .rn_addr               (rn_addr),
    .reg_write_addr        (reg_write_addr),
    .literal               (literal)
  );

endmodule

`default_nettype wire

//--- tests/decode_assert.sv
`default_nettype none

module decode_assert #(
  parameter int DATA_WIDTH = 32
) (
  input wire logic                  clk,
  input wire logic                  rst_n,
  input wire logic                  next_ready,
  input wire logic                  control_valid,
  input wire logic                  illegal_inst,
  input wire decode_pkg::alu_op_e   alu_opcode,
  input wire logic                  op2_is_literal,
  input wire logic                  ext_16,
  input wire logic                  set_flags,
  input wire logic                  mem_read,
  input wire logic                  mem_write,
  input wire logic                  reg_write,
  input wire logic                  reg_write_from_mem,
  input wire decode_pkg::reg_addr_t rd_addr,
  input wire decode_pkg::reg_addr_t rn_addr,
  input wire decode_pkg::reg_addr_t reg_write_addr,
  input wire logic [DATA_WIDTH-1:0] literal
);

  logic [DATA_WIDTH+23:0] bundle;

  assign bundle = {illegal_inst, alu_opcode, op2_is_literal, ext_16, set_flags,
                   mem_read, mem_write, reg_write, reg_write_from_mem,
                   rd_addr, rn_addr, reg_write_addr, literal};

  // A stalled bundle must not move
  hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    control_valid && !next_ready |=> control_valid && $stable(bundle))
    else $error("output bundle changed while stalled");

  illegal_no_enable: assert property (@(posedge clk) disable iff (!rst_n)
    illegal_inst |-> !(set_flags || mem_read || mem_write || reg_write))
    else $error("illegal instruction carries an enable");

  mem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_read && mem_write))
    else $error("mem_read and mem_write both high");

endmodule

bind ctrl_issue decode_assert #(
  .DATA_WIDTH(DATA_WIDTH)
) u_decode_assert (
  .clk               (clk),
  .rst_n             (rst_n),
  .next_ready        (next_ready),
  .control_valid     (control_valid),
  .illegal_inst      (illegal_inst),
  .alu_opcode        (alu_opcode),
  .op2_is_literal    (op2_is_literal),
  .ext_16            (ext_16),
  .set_flags         (set_flags),
  .mem_read          (mem_read),
  .mem_write         (mem_write),
  .reg_write         (reg_write),
  .reg_write_from_mem(reg_write_from_mem),
  .rd_addr           (rd_addr),
  .rn_addr           (rn_addr),
  .reg_write_addr    (reg_write_addr),
  .literal           (literal)
);

`default_nettype wire

//--- tests/decode_tb.sv
`default_nettype none

module decode_tb;

  localparam int DATA_WIDTH      = 32;
  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 8;
  localparam int NUM_RANDOM      = 2000;
  localparam int SEED            = 16889;
  localparam int WATCHDOG_CYCLES = NUM_RANDOM * 8;
  localparam int DRAIN_LIMIT     = 20;

  // One expected control bundle per accepted instruction
  typedef struct packed {
    logic                  illegal;
    decode_pkg::alu_op_e   alu_opcode;
    logic                  op2_is_literal;
    logic                  ext_16;
    logic                  set_flags;
    logic                  mem_read;
    logic                  mem_write;
    logic                  reg_write;
    logic                  reg_write_from_mem;
    decode_pkg::reg_addr_t rd_addr;
    decode_pkg::reg_addr_t rn_addr;
    decode_pkg::reg_addr_t reg_write_addr;
    logic [DATA_WIDTH-1:0] literal;
  } bundle_t;

  logic                  clk;
  logic                  rst_n;
  decode_pkg::inst_t     instruction;
  logic                  inst_valid;
  logic                  next_ready;
  logic                  decode_ready;
  logic                  control_valid;
  decode_pkg::reg_addr_t rd_addr;
  decode_pkg::reg_addr_t rn_addr;
  decode_pkg::reg_addr_t reg_write_addr;
  logic [DATA_WIDTH-1:0] literal;
  logic                  op2_is_literal;
  logic                  ext_16;
  decode_pkg::alu_op_e   alu_opcode;
  logic                  set_flags;
  logic                  mem_read;
  logic                  mem_write;
  logic                  reg_write;
  logic                  reg_write_from_mem;
  logic                  illegal_inst;

  bundle_t expect_q[$];
  int      error_count;
  int      bundle_count;

  decode_top #(
    .DATA_WIDTH(DATA_WIDTH)
  ) dut_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .instruction       (instruction),
    .inst_valid        (inst_valid),
    .next_ready        (next_ready),
    .decode_ready      (decode_ready),
    .control_valid     (control_valid),
    .rd_addr           (rd_addr),
    .rn_addr           (rn_addr),
    .literal           (literal),
    .op2_is_literal    (op2_is_literal),
    .ext_16            (ext_16),
    .alu_opcode        (alu_opcode),
    .set_flags         (set_flags),
    .mem_read          (mem_read),
    .mem_write         (mem_write),
    .reg_write         (reg_write),
    .reg_write_from_mem(reg_write_from_mem),
    .reg_write_addr    (reg_write_addr),
    .illegal_inst      (illegal_inst)
  );

  initial clk = 1'b0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Expected decode for each instruction class
  function automatic bundle_t ref_decode(input decode_pkg::inst_t word);
    bundle_t    b;
    logic [3:0] ident;
    b     = '0;
    ident = word[15:12];
    if (ident == 4'b0000)
    begin
      b.alu_opcode = decode_pkg::ALU_AND;
    end
    else if (ident == 4'b0001)
    begin
      b.alu_opcode     = word[11] ? decode_pkg::ALU_ZEX : decode_pkg::ALU_SEX;
      b.ext_16         = word[10];
      b.reg_write      = 1'b1;
      b.rd_addr        = word[7:4];
      b.reg_write_addr = word[7:4];
    end
    else
    begin
      case (ident[3:1])
        3'b010:
        begin
          b.alu_opcode     = decode_pkg::ALU_MOV;
          b.op2_is_literal = word[12];
          b.reg_write      = 1'b1;
          b.rn_addr        = word[3:0];
          b.reg_write_addr = word[11:8];
          b.literal        = DATA_WIDTH'(word[7:0]);
        end
        3'b011:
        begin
          b.alu_opcode         = decode_pkg::ALU_ADD;
          b.op2_is_literal     = 1'b1;
          b.mem_read           = !word[12];
          b.mem_write          = word[12];
          b.reg_write          = !word[12];
          b.reg_write_from_mem = !word[12];
          b.rd_addr            = word[7:4];
          b.rn_addr            = word[11:8];
          b.reg_write_addr     = word[11:8];
          b.literal            = DATA_WIDTH'(word[3:0]);
        end
        3'b100:
        begin
          b.alu_opcode     = decode_pkg::alu_op_e'(word[11:8]);
          b.op2_is_literal = !word[12];
          b.set_flags      = 1'b1;
          b.reg_write      = 1'b1;
          b.rd_addr        = word[7:4];
          b.rn_addr        = word[3:0];
          b.reg_write_addr = word[7:4];
          b.literal        = DATA_WIDTH'(word[3:0]);
        end
        3'b101:
        begin
          // Shift ops sit at 0xc and up
          b.alu_opcode     = decode_pkg::alu_op_e'(4'hc + {2'b00, word[7:6]});
          b.op2_is_literal = !word[12];
          b.set_flags      = 1'b1;
          b.reg_write      = 1'b1;
          b.rd_addr        = word[11:8];
          b.rn_addr        = word[3:0];
          b.reg_write_addr = word[11:8];
          b.literal        = DATA_WIDTH'(word[4:0]);
        end
        default:
        begin
          b.illegal = 1'b1;
        end
      endcase
    end
    return b;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_addr(input string name, input decode_pkg::reg_addr_t got,
                            input decode_pkg::reg_addr_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_literal(input string name, input logic [DATA_WIDTH-1:0] got,
                               input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_op(input string name, input decode_pkg::alu_op_e got,
                          input decode_pkg::alu_op_e exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  // No side effect may leave the stage without a valid bundle
  task automatic check_idle_outputs();
    check_bit("illegal_inst", illegal_inst, 1'b0);
    check_bit("set_flags", set_flags, 1'b0);
    check_bit("mem_read", mem_read, 1'b0);
    check_bit("mem_write", mem_write, 1'b0);
    check_bit("reg_write", reg_write, 1'b0);
  endtask

  task automatic compare_bundle(input bundle_t exp);
    bundle_count++;
    check_bit("illegal_inst", illegal_inst, exp.illegal);
    check_op("alu_opcode", alu_opcode, exp.alu_opcode);
    check_bit("op2_is_literal", op2_is_literal, exp.op2_is_literal);
    check_bit("ext_16", ext_16, exp.ext_16);
    check_bit("set_flags", set_flags, exp.set_flags);
    check_bit("mem_read", mem_read, exp.mem_read);
    check_bit("mem_write", mem_write, exp.mem_write);
    check_bit("reg_write", reg_write, exp.reg_write);
    check_bit("reg_write_from_mem", reg_write_from_mem, exp.reg_write_from_mem);
    check_addr("rd_addr", rd_addr, exp.rd_addr);
    check_addr("rn_addr", rn_addr, exp.rn_addr);
    check_addr("reg_write_addr", reg_write_addr, exp.reg_write_addr);
    check_literal("literal", literal, exp.literal);
  endtask

  // Consume before accept on pre-edge values
  always @(posedge clk)
  begin
    if (rst_n)
    begin
      check_bit("decode_ready", decode_ready, next_ready);
      if (!control_valid)
        check_idle_outputs();
      if (control_valid && next_ready)
      begin
        if (expect_q.size() == 0)
        begin
          $display("Output bundle appeared with no accepted instruction pending");
          error_count++;
        end
        else
        begin
          compare_bundle(expect_q.pop_front());
        end
      end
      if (inst_valid && next_ready)
        expect_q.push_back(ref_decode(instruction));
    end
  end

  task automatic measure_latency(input decode_pkg::inst_t word);
    int edges;
    @(posedge clk);
    instruction <= word;
    inst_valid  <= 1'b1;
    next_ready  <= 1'b1;
    // Accepting edge counts as the first
    @(posedge clk);
    inst_valid <= 1'b0;
    edges = 1;
    @(negedge clk);
    while (!control_valid && edges < 8)
    begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    if (!control_valid)
    begin
      $display("control_valid never rose after an accepted instruction");
      error_count++;
    end
    else if (edges != 2)
    begin
      $display("control_valid rose after %0d edges instead of 2", edges);
      error_count++;
    end
  endtask

  initial
  begin
    int accepted;
    error_count  = 0;
    bundle_count = 0;
    accepted     = 0;
    void'($urandom(SEED));
    rst_n       = 1'b0;
    instruction = '0;
    inst_valid  = 1'b0;
    next_ready  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("control_valid", control_valid, 1'b0);
    check_idle_outputs();

    measure_latency(16'h8123);

    // Every class code twice back to back
    for (int ident = 0; ident < 32; ident++)
    begin
      @(posedge clk);
      instruction <= {4'(ident % 16), 12'($urandom)};
      inst_valid  <= 1'b1;
      next_ready  <= 1'b1;
    end
    @(posedge clk);
    inst_valid <= 1'b0;

    while (accepted < NUM_RANDOM)
    begin
      @(posedge clk);
      if (inst_valid && next_ready)
        accepted++;
      if (accepted < NUM_RANDOM)
      begin
        instruction <= decode_pkg::inst_t'($urandom);
        inst_valid  <= ($urandom % 4) != 0;
        next_ready  <= ($urandom % 4) != 0;
      end
    end
    inst_valid <= 1'b0;
    next_ready <= 1'b1;

    for (int i = 0; i < DRAIN_LIMIT && expect_q.size() != 0; i++)
      @(negedge clk);
    if (expect_q.size() != 0)
    begin
      $display("%0d accepted instructions never reached the output", expect_q.size());
      error_count++;
    end

    $display("Bundles compared: %0d, errors: %0d", bundle_count, error_count);
    if (error_count == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
verilog/decode_pkg.sv
verilog/inst_capture.sv
verilog/class_decode.sv
verilog/operand_select.sv
verilog/ctrl_issue.sv
verilog/decode_top.sv
tests/decode_assert.sv
tests/decode_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module decode_tb -f tb.f -Mdir obj_dir
	./obj_dir/Vdecode_tb | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
